// File: common/bridge_macros.svh
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// byte address width on the cpu side and on the axi bus
`define BUS_ADDR_WIDTH 32

// data word width
`define BUS_DATA_WIDTH 32

// one strobe bit per data byte
`define BUS_STRB_WIDTH (`BUS_DATA_WIDTH / 8)

// memory depth in words, 1 KiB in total
`define MEM_WORDS 256

// axi write and read response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

// File: common/bridge_pkg.sv
`include "bridge_macros.svh"

package bridge_pkg;

    // byte address on both sides of the bridge
    typedef logic [`BUS_ADDR_WIDTH-1:0] addr_t;

    // one data word
    typedef logic [`BUS_DATA_WIDTH-1:0] data_t;

    // byte enables of a word
    typedef logic [`BUS_STRB_WIDTH-1:0] strb_t;

    // axi bresp / rresp
    typedef logic [1:0] resp_t;

    // bridge read channel
    typedef enum logic {
        rd_idle,
        rd_busy
    } rd_state_e;

    // bridge write channel
    // busy covers the aw/w phase and the wait for b
    typedef enum logic {
        wr_idle,
        wr_busy
    } wr_state_e;

endpackage

// File: compile.f
+incdir+common
common/bridge_pkg.sv
sram2axi/sram2axi4_lite.sv
logic/axi_lite_sram.sv
logic/cpu_mem_top.sv
verif/tb_clock_gen.sv
verif/cpu_mem_properties.sv
verif/tb_cpu_mem.sv

// File: logic/axi_lite_sram.sv
`timescale 1ns/100ps

`include "bridge_macros.svh"

module axi_lite_sram (
    input  logic               aclk,
    input  logic               reset,

    // write address and data
    input  logic               aw_valid,
    output logic               aw_ready,
    input  bridge_pkg::addr_t  aw_addr,
    input  logic               w_valid,
    output logic               w_ready,
    input  bridge_pkg::data_t  w_data,
    input  bridge_pkg::strb_t  w_strb,

    // write response
    output logic               b_valid,
    input  logic               b_ready,
    output bridge_pkg::resp_t  b_resp,

    // read address and data
    input  logic               ar_valid,
    output logic               ar_ready,
    input  bridge_pkg::addr_t  ar_addr,
    output logic               r_valid,
    input  logic               r_ready,
    output bridge_pkg::data_t  r_data,
    output bridge_pkg::resp_t  r_resp
);

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int unsigned MEM_BYTES = `MEM_WORDS * 4;

    bridge_pkg::data_t mem [`MEM_WORDS];

    logic             wr_fire;
    logic             rd_fire;
    logic             wr_in_range;
    logic             rd_in_range;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // take aw and w together, only with room for the b response
    assign aw_ready = aw_valid & w_valid & ~b_valid;
    assign w_ready  = aw_ready;

    // one read response slot
    assign ar_ready = ~r_valid;

    assign wr_fire = aw_valid & aw_ready & w_valid & w_ready;
    assign rd_fire = ar_valid & ar_ready;

    // word index from the byte address
    assign wr_idx = aw_addr[IDX_W+1:2];
    assign rd_idx = ar_addr[IDX_W+1:2];

    assign wr_in_range = (aw_addr < MEM_BYTES);
    assign rd_in_range = (ar_addr < MEM_BYTES);

    // byte merge under strobe
    // out of range writes are dropped
    always_ff @(posedge aclk) begin
        if (wr_fire && wr_in_range) begin
            for (int i = 0; i < `BUS_STRB_WIDTH; i++) begin
                if (w_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w_data[8*i +: 8];
                end
            end
        end
    end

    // b response slot
    always_ff @(posedge aclk) begin
        if (!reset) begin
            b_valid <= 1'b0;
        end else if (wr_fire) begin
            b_valid <= 1'b1;
        end else if (b_valid && b_ready) begin
            b_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            b_resp <= wr_in_range ? `RESP_OKAY : `RESP_SLVERR;
        end
    end

    // r response slot
    always_ff @(posedge aclk) begin
        if (!reset) begin
            r_valid <= 1'b0;
        end else if (rd_fire) begin
            r_valid <= 1'b1;
        end else if (r_valid && r_ready) begin
            r_valid <= 1'b0;
        end
    end

    // word captured at the ar handshake
    // a later write leaves this read alone
    always_ff @(posedge aclk) begin
        if (rd_fire) begin
            r_data <= rd_in_range ? mem[rd_idx] : '0;
            r_resp <= rd_in_range ? `RESP_OKAY : `RESP_SLVERR;
        end
    end

endmodule

// File: logic/cpu_mem_top.sv
`timescale 1ns/100ps

module cpu_mem_top (
    input  logic               aclk,
    input  logic               reset,

    // instruction port
    input  logic               inst_ce,
    input  logic               inst_we,
    input  bridge_pkg::addr_t  inst_addr,
    input  bridge_pkg::data_t  inst_wdata,
    input  bridge_pkg::strb_t  inst_wmask,
    output bridge_pkg::data_t  inst_rdata,
    output logic               inst_rdata_valid,
    output logic               inst_write_finish,
    output logic               inst_err,

    // data port
    input  logic               data_ce,
    input  logic               data_we,
    input  bridge_pkg::addr_t  data_addr,
    input  bridge_pkg::data_t  data_wdata,
    input  bridge_pkg::strb_t  data_wmask,
    output bridge_pkg::data_t  data_rdata,
    output logic               data_rdata_valid,
    output logic               data_write_finish,
    output logic               data_err
);

    // axi4-lite between bridge and memory
    logic              aw_valid;
    logic              aw_ready;
    bridge_pkg::addr_t aw_addr;
    logic              w_valid;
    logic              w_ready;
    bridge_pkg::data_t w_data;
    bridge_pkg::strb_t w_strb;
    logic              b_valid;
    logic              b_ready;
    bridge_pkg::resp_t b_resp;
    logic              ar_valid;
    logic              ar_ready;
    bridge_pkg::addr_t ar_addr;
    logic              r_valid;
    logic              r_ready;
    bridge_pkg::data_t r_data;
    bridge_pkg::resp_t r_resp;

    sram2axi4_lite i_bridge (
        .aclk              (aclk),
        .reset             (reset),
        .inst_ce           (inst_ce),
        .inst_we           (inst_we),
        .inst_addr         (inst_addr),
        .inst_wdata        (inst_wdata),
        .inst_wmask        (inst_wmask),
        .inst_rdata        (inst_rdata),
        .inst_rdata_valid  (inst_rdata_valid),
        .inst_write_finish (inst_write_finish),
        .inst_err          (inst_err),
        .data_ce           (data_ce),
        .data_we           (data_we),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_wmask        (data_wmask),
        .data_rdata        (data_rdata),
        .data_rdata_valid  (data_rdata_valid),
        .data_write_finish (data_write_finish),
        .data_err          (data_err),
        .aw_valid          (aw_valid),
        .aw_ready          (aw_ready),
        .aw_addr           (aw_addr),
        .w_valid           (w_valid),
        .w_ready           (w_ready),
        .w_data            (w_data),
        .w_strb            (w_strb),
        .b_valid           (b_valid),
        .b_ready           (b_ready),
        .b_resp            (b_resp),
        .ar_valid          (ar_valid),
        .ar_ready          (ar_ready),
        .ar_addr           (ar_addr),
        .r_valid           (r_valid),
        .r_ready           (r_ready),
        .r_data            (r_data),
        .r_resp            (r_resp)
    );

    // word memory behind the bridge
    axi_lite_sram i_mem (
        .aclk     (aclk),
        .reset    (reset),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_resp   (b_resp),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .r_resp   (r_resp)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f compile.f --top-module tb_cpu_mem -o tb_cpu_mem_sim

sim_out=$(./obj_dir/tb_cpu_mem_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "run_sim: pass line not found in the simulation output"
exit 1

// File: sram2axi/sram2axi4_lite.sv
`timescale 1ns/100ps

`include "bridge_macros.svh"

module sram2axi4_lite (
    input  logic               aclk,
    input  logic               reset,

    // instruction port
    input  logic               inst_ce,
    input  logic               inst_we,
    input  bridge_pkg::addr_t  inst_addr,
    input  bridge_pkg::data_t  inst_wdata,
    input  bridge_pkg::strb_t  inst_wmask,
    output bridge_pkg::data_t  inst_rdata,
    output logic               inst_rdata_valid,
    output logic               inst_write_finish,
    output logic               inst_err,

    // data port
    input  logic               data_ce,
    input  logic               data_we,
    input  bridge_pkg::addr_t  data_addr,
    input  bridge_pkg::data_t  data_wdata,
    input  bridge_pkg::strb_t  data_wmask,
    output bridge_pkg::data_t  data_rdata,
    output logic               data_rdata_valid,
    output logic               data_write_finish,
    output logic               data_err,

    // axi4-lite master
    output logic               aw_valid,
    input  logic               aw_ready,
    output bridge_pkg::addr_t  aw_addr,
    output logic               w_valid,
    input  logic               w_ready,
    output bridge_pkg::data_t  w_data,
    output bridge_pkg::strb_t  w_strb,
    input  logic               b_valid,
    output logic               b_ready,
    input  bridge_pkg::resp_t  b_resp,
    output logic               ar_valid,
    input  logic               ar_ready,
    output bridge_pkg::addr_t  ar_addr,
    input  logic               r_valid,
    output logic               r_ready,
    input  bridge_pkg::data_t  r_data,
    input  bridge_pkg::resp_t  r_resp
);

    bridge_pkg::rd_state_e rd_state;
    bridge_pkg::wr_state_e wr_state;

    // owner of the outstanding transaction, 0 data port, 1 inst port
    logic rd_owner;
    logic wr_owner;

    logic rsp_ready;

    logic rd_sel_data;
    logic rd_sel_inst;
    logic wr_sel_data;
    logic wr_sel_inst;
    logic wr_start;
    logic rd_block;
    logic rd_start;
    logic rd_take;
    logic wr_take;

    // requests seen by each channel, ce only counts in idle states
    assign rd_sel_data = data_ce & ~data_we;
    assign rd_sel_inst = inst_ce & ~inst_we;
    assign wr_sel_data = data_ce & data_we;
    assign wr_sel_inst = inst_ce & inst_we;

    assign wr_start = (wr_state == bridge_pkg::wr_idle) & (wr_sel_data | wr_sel_inst);

    // no read while a write is accepted or in flight
    // keeps every read behind all earlier writes
    assign rd_block = (wr_state == bridge_pkg::wr_busy) | wr_start;
    assign rd_start = (rd_state == bridge_pkg::rd_idle) & ~rd_block
                    & (rd_sel_data | rd_sel_inst);

    assign rd_take = (rd_state == bridge_pkg::rd_busy) & r_valid & r_ready;
    assign wr_take = (wr_state == bridge_pkg::wr_busy) & b_valid & b_ready;

    // response channels always open once out of reset
    always_ff @(posedge aclk) begin
        if (!reset) begin
            rsp_ready <= 1'b0;
        end else begin
            rsp_ready <= 1'b1;
        end
    end

    assign r_ready = rsp_ready;
    assign b_ready = rsp_ready;

    // write FSM, data port first
    always_ff @(posedge aclk) begin
        if (!reset) begin
            wr_state <= bridge_pkg::wr_idle;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            wr_owner <= 1'b0;
        end else begin
            case (wr_state)
                bridge_pkg::wr_idle: begin
                    if (wr_start) begin
                        wr_state <= bridge_pkg::wr_busy;
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                        wr_owner <= ~wr_sel_data;
                    end
                end
                bridge_pkg::wr_busy: begin
                    // drop each valid on its own handshake
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_valid && w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (wr_take) begin
                        wr_state <= bridge_pkg::wr_idle;
                    end
                end
            endcase
        end
    end

    // read FSM, data port first
    always_ff @(posedge aclk) begin
        if (!reset) begin
            rd_state <= bridge_pkg::rd_idle;
            ar_valid <= 1'b0;
            rd_owner <= 1'b0;
        end else begin
            case (rd_state)
                bridge_pkg::rd_idle: begin
                    if (rd_start) begin
                        rd_state <= bridge_pkg::rd_busy;
                        ar_valid <= 1'b1;
                        rd_owner <= ~rd_sel_data;
                    end
                end
                bridge_pkg::rd_busy: begin
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (rd_take) begin
                        rd_state <= bridge_pkg::rd_idle;
                    end
                end
            endcase
        end
    end

    // request payload, latched on accept and held until the handshake
    always_ff @(posedge aclk) begin
        if (wr_start) begin
            if (wr_sel_data) begin
                aw_addr <= data_addr;
                w_data  <= data_wdata;
                w_strb  <= data_wmask;
            end else begin
                aw_addr <= inst_addr;
                w_data  <= inst_wdata;
                w_strb  <= inst_wmask;
            end
        end
        if (rd_start) begin
            ar_addr <= rd_sel_data ? data_addr : inst_addr;
        end
    end

    // completion pulses back to the owning port
    always_ff @(posedge aclk) begin
        if (!reset) begin
            data_rdata_valid  <= 1'b0;
            inst_rdata_valid  <= 1'b0;
            data_write_finish <= 1'b0;
            inst_write_finish <= 1'b0;
            data_err          <= 1'b0;
            inst_err          <= 1'b0;
        end else begin
            data_rdata_valid  <= rd_take & ~rd_owner;
            inst_rdata_valid  <= rd_take & rd_owner;
            data_write_finish <= wr_take & ~wr_owner;
            inst_write_finish <= wr_take & wr_owner;
            // a port has one request in flight, so at most one term is set
            data_err <= (rd_take & ~rd_owner & (r_resp == `RESP_SLVERR))
                      | (wr_take & ~wr_owner & (b_resp == `RESP_SLVERR));
            inst_err <= (rd_take & rd_owner & (r_resp == `RESP_SLVERR))
                      | (wr_take & wr_owner & (b_resp == `RESP_SLVERR));
        end
    end

    // read data per port, valid with the pulse
    always_ff @(posedge aclk) begin
        if (rd_take && !rd_owner) begin
            data_rdata <= r_data;
        end
        if (rd_take && rd_owner) begin
            inst_rdata <= r_data;
        end
    end

endmodule

// File: verif/cpu_mem_properties.sv
`timescale 1ns/100ps

module cpu_mem_properties (
    input logic                  aclk,
    input logic                  reset,
    input logic                  aw_valid,
    input logic                  aw_ready,
    input bridge_pkg::addr_t     aw_addr,
    input logic                  w_valid,
    input logic                  w_ready,
    input bridge_pkg::data_t     w_data,
    input bridge_pkg::strb_t     w_strb,
    input logic                  ar_valid,
    input logic                  ar_ready,
    input bridge_pkg::addr_t     ar_addr,
    input bridge_pkg::wr_state_e wr_state,
    input logic                  data_rdata_valid,
    input logic                  inst_rdata_valid,
    input logic                  data_write_finish,
    input logic                  inst_write_finish
);

    logic any_pulse;

    assign any_pulse = data_rdata_valid | inst_rdata_valid
                     | data_write_finish | inst_write_finish;

    // write address held with its payload until accepted
    aw_hold: assert property (@(posedge aclk) disable iff (!reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("aw_valid or aw_addr changed before the aw handshake");

    w_hold: assert property (@(posedge aclk) disable iff (!reset)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
        else $error("w_valid or w payload changed before the w handshake");

    ar_hold: assert property (@(posedge aclk) disable iff (!reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_valid or ar_addr changed before the ar handshake");

    // aw and w always travel as a pair
    aw_w_pair: assert property (@(posedge aclk) disable iff (!reset)
        aw_valid == w_valid)
        else $error("aw_valid and w_valid differ");

    // reads only behind finished writes
    read_after_write: assert property (@(posedge aclk) disable iff (!reset)
        ar_valid && ar_ready |-> wr_state == bridge_pkg::wr_idle)
        else $error("ar transfer while the write channel is busy");

    // registers cleared by reset, checked one edge later
    reset_quiet: assert property (@(posedge aclk)
        !reset |=> !any_pulse)
        else $error("completion pulse seen during reset");

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic aclk,
    output logic reset
);

    // 8 ns period
    initial begin
        aclk = 1'b0;
        forever begin
            #4 aclk = ~aclk;
        end
    end

    // active low for four cycles, released on a falling edge
    initial begin
        reset = 1'b0;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b1;
    end

endmodule

// File: verif/tb_cpu_mem.sv
`timescale 1ns/100ps

`include "bridge_macros.svh"

module tb_cpu_mem;

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int NUM_WORDS = 32;
    // several times the length of all tests
    localparam int TIMEOUT_CYCLES = 3000;
    localparam bridge_pkg::addr_t MEM_BYTES = `MEM_WORDS * 4;

    logic              aclk;
    logic              reset;
    logic              inst_ce;
    logic              inst_we;
    bridge_pkg::addr_t inst_addr;
    bridge_pkg::data_t inst_wdata;
    bridge_pkg::strb_t inst_wmask;
    bridge_pkg::data_t inst_rdata;
    logic              inst_rdata_valid;
    logic              inst_write_finish;
    logic              inst_err;
    logic              data_ce;
    logic              data_we;
    bridge_pkg::addr_t data_addr;
    bridge_pkg::data_t data_wdata;
    bridge_pkg::strb_t data_wmask;
    bridge_pkg::data_t data_rdata;
    logic              data_rdata_valid;
    logic              data_write_finish;
    logic              data_err;

    // reference copy of the word memory
    bridge_pkg::data_t model [`MEM_WORDS];
    bridge_pkg::addr_t test_addr [NUM_WORDS];
    int unsigned       lcg_state = 25;
    int                cycle_count = 0;

    tb_clock_gen i_clk (
        .aclk  (aclk),
        .reset (reset)
    );

    cpu_mem_top i_dut (
        .aclk              (aclk),
        .reset             (reset),
        .inst_ce           (inst_ce),
        .inst_we           (inst_we),
        .inst_addr         (inst_addr),
        .inst_wdata        (inst_wdata),
        .inst_wmask        (inst_wmask),
        .inst_rdata        (inst_rdata),
        .inst_rdata_valid  (inst_rdata_valid),
        .inst_write_finish (inst_write_finish),
        .inst_err          (inst_err),
        .data_ce           (data_ce),
        .data_we           (data_we),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_wmask        (data_wmask),
        .data_rdata        (data_rdata),
        .data_rdata_valid  (data_rdata_valid),
        .data_write_finish (data_write_finish),
        .data_err          (data_err)
    );

    // handshake checks inside the bridge
    bind sram2axi4_lite cpu_mem_properties i_props (
        .aclk              (aclk),
        .reset             (reset),
        .aw_valid          (aw_valid),
        .aw_ready          (aw_ready),
        .aw_addr           (aw_addr),
        .w_valid           (w_valid),
        .w_ready           (w_ready),
        .w_data            (w_data),
        .w_strb            (w_strb),
        .ar_valid          (ar_valid),
        .ar_ready          (ar_ready),
        .ar_addr           (ar_addr),
        .wr_state          (wr_state),
        .data_rdata_valid  (data_rdata_valid),
        .inst_rdata_valid  (inst_rdata_valid),
        .data_write_finish (data_write_finish),
        .inst_write_finish (inst_write_finish)
    );

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic in_range(input bridge_pkg::addr_t a);
        return a < MEM_BYTES;
    endfunction

    // strobed bytes only
    // nothing stored outside the memory
    function automatic void model_write(input bridge_pkg::addr_t a, input bridge_pkg::data_t d,
                                        input bridge_pkg::strb_t m);
        if (in_range(a)) begin
            for (int i = 0; i < `BUS_STRB_WIDTH; i++) begin
                if (m[i]) begin
                    model[a[IDX_W+1:2]][8*i +: 8] = d[8*i +: 8];
                end
            end
        end
    endfunction

    function automatic bridge_pkg::data_t model_read(input bridge_pkg::addr_t a);
        return in_range(a) ? model[a[IDX_W+1:2]] : '0;
    endfunction

    task automatic compare_word(input string name, input bridge_pkg::data_t got,
                                input bridge_pkg::data_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic verify_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic start_request(input bit use_inst, input logic we, input bridge_pkg::addr_t a,
                                 input bridge_pkg::data_t d, input bridge_pkg::strb_t m);
        if (use_inst) begin
            inst_ce    = 1'b1;
            inst_we    = we;
            inst_addr  = a;
            inst_wdata = d;
            inst_wmask = m;
        end else begin
            data_ce    = 1'b1;
            data_we    = we;
            data_addr  = a;
            data_wdata = d;
            data_wmask = m;
        end
    endtask

    task automatic stop_request(input bit use_inst);
        if (use_inst) begin
            inst_ce = 1'b0;
            inst_we = 1'b0;
        end else begin
            data_ce = 1'b0;
            data_we = 1'b0;
        end
    endtask

    // completion pulse of one port for one kind of request
    function automatic logic done_pulse(input bit use_inst, input logic we);
        if (use_inst) begin
            return we ? inst_write_finish : inst_rdata_valid;
        end
        return we ? data_write_finish : data_rdata_valid;
    endfunction

    // counts falling edges until the pulse
    task automatic wait_done(input bit use_inst, input logic we, output int lat,
                             output bridge_pkg::data_t rd, output logic er);
        lat = 0;
        do begin
            @(negedge aclk);
            lat++;
        end while (!done_pulse(use_inst, we));
        rd = use_inst ? inst_rdata : data_rdata;
        er = use_inst ? inst_err : data_err;
    endtask

    // one uncontended request with fixed 3 cycle latency
    task automatic single_access(input bit use_inst, input logic we, input bridge_pkg::addr_t a,
                                 input bridge_pkg::data_t d, input bridge_pkg::strb_t m);
        int                lat;
        bridge_pkg::data_t rd;
        logic              er;
        string             port;
        port = use_inst ? "inst" : "data";
        start_request(use_inst, we, a, d, m);
        wait_done(use_inst, we, lat, rd, er);
        // inputs may change inside the completion cycle
        stop_request(use_inst);
        expect_flag({port, "_err"}, er, !in_range(a));
        verify_latency({port, " latency"}, lat, 3);
        if (we) begin
            model_write(a, d, m);
        end else begin
            compare_word({port, "_rdata"}, rd, model_read(a));
        end
        @(negedge aclk);
        // pulse lasts one cycle
        expect_flag({port, " pulse width"}, done_pulse(use_inst, we), 1'b0);
    endtask

    // both ports raise ce in the same cycle with full masks
    task automatic dual_access(input logic d_we, input bridge_pkg::addr_t d_a,
                               input bridge_pkg::data_t d_d, input logic i_we,
                               input bridge_pkg::addr_t i_a, input bridge_pkg::data_t i_d,
                               output int d_lat, output int i_lat,
                               output bridge_pkg::data_t d_rd, output bridge_pkg::data_t i_rd,
                               output logic d_er, output logic i_er);
        int lat;
        bit d_done;
        bit i_done;
        lat = 0;
        d_done = 1'b0;
        i_done = 1'b0;
        start_request(1'b0, d_we, d_a, d_d, '1);
        start_request(1'b1, i_we, i_a, i_d, '1);
        while (!(d_done && i_done)) begin
            @(negedge aclk);
            lat++;
            if (!d_done && done_pulse(1'b0, d_we)) begin
                d_done = 1'b1;
                d_lat = lat;
                d_rd = data_rdata;
                d_er = data_err;
                stop_request(1'b0);
            end
            if (!i_done && done_pulse(1'b1, i_we)) begin
                i_done = 1'b1;
                i_lat = lat;
                i_rd = inst_rdata;
                i_er = inst_err;
                stop_request(1'b1);
            end
        end
        @(negedge aclk);
    endtask

    // full words spread over the memory and read back
    task automatic data_port_sweep();
        for (int k = 0; k < NUM_WORDS; k++) begin
            test_addr[k] = k * 32;
            single_access(1'b0, 1'b1, test_addr[k], next_rand(), '1);
        end
        for (int k = 0; k < NUM_WORDS; k++) begin
            single_access(1'b0, 1'b0, test_addr[k], '0, '0);
        end
    endtask

    task automatic inst_partial_masks();
        int unsigned       r;
        bridge_pkg::strb_t m;
        for (int k = 0; k < 16; k++) begin
            r = next_rand();
            m = r[3:0];
            // keep the mask partial
            if (m == '0 || m == '1) begin
                m = 4'b0110;
            end
            single_access(1'b1, 1'b1, test_addr[k], next_rand(), m);
        end
        for (int k = 0; k < 16; k++) begin
            single_access(1'b1, 1'b0, test_addr[k], '0, '0);
        end
    endtask

    task automatic read_contention();
        int                d_lat;
        int                i_lat;
        bridge_pkg::data_t d_rd;
        bridge_pkg::data_t i_rd;
        logic              d_er;
        logic              i_er;
        dual_access(1'b0, test_addr[3], '0, 1'b0, test_addr[20], '0,
                    d_lat, i_lat, d_rd, i_rd, d_er, i_er);
        verify_latency("data latency", d_lat, 3);
        expect_flag("data before inst", i_lat > d_lat, 1'b1);
        compare_word("data_rdata", d_rd, model_read(test_addr[3]));
        compare_word("inst_rdata", i_rd, model_read(test_addr[20]));
        expect_flag("data_err", d_er, 1'b0);
        expect_flag("inst_err", i_er, 1'b0);
    endtask

    // read of the same word waits for the write
    task automatic write_then_read();
        int                d_lat;
        int                i_lat;
        bridge_pkg::data_t d_rd;
        bridge_pkg::data_t i_rd;
        logic              d_er;
        logic              i_er;
        bridge_pkg::data_t fresh;
        fresh = next_rand();
        dual_access(1'b1, test_addr[5], fresh, 1'b0, test_addr[5], '0,
                    d_lat, i_lat, d_rd, i_rd, d_er, i_er);
        model_write(test_addr[5], fresh, '1);
        verify_latency("data write latency", d_lat, 3);
        expect_flag("write before read", i_lat > d_lat, 1'b1);
        compare_word("inst_rdata", i_rd, model_read(test_addr[5]));
        expect_flag("data_err", d_er, 1'b0);
        expect_flag("inst_err", i_er, 1'b0);
    endtask

    task automatic write_contention();
        int                d_lat;
        int                i_lat;
        bridge_pkg::data_t d_rd;
        bridge_pkg::data_t i_rd;
        logic              d_er;
        logic              i_er;
        bridge_pkg::data_t d_word;
        bridge_pkg::data_t i_word;
        d_word = next_rand();
        i_word = next_rand();
        dual_access(1'b1, test_addr[8], d_word, 1'b1, test_addr[9], i_word,
                    d_lat, i_lat, d_rd, i_rd, d_er, i_er);
        model_write(test_addr[8], d_word, '1);
        model_write(test_addr[9], i_word, '1);
        verify_latency("data write latency", d_lat, 3);
        expect_flag("data before inst", i_lat > d_lat, 1'b1);
        expect_flag("data_err", d_er, 1'b0);
        expect_flag("inst_err", i_er, 1'b0);
        single_access(1'b0, 1'b0, test_addr[8], '0, '0);
        single_access(1'b0, 1'b0, test_addr[9], '0, '0);
    endtask

    // address aliases an in-range word in the low bits
    task automatic out_of_range();
        bridge_pkg::addr_t far_addr;
        far_addr = test_addr[1] + MEM_BYTES;
        single_access(1'b0, 1'b1, far_addr, next_rand(), '1);
        single_access(1'b0, 1'b0, test_addr[1], '0, '0);
        single_access(1'b1, 1'b0, far_addr, '0, '0);
    endtask

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        inst_ce    = 1'b0;
        inst_we    = 1'b0;
        inst_addr  = '0;
        inst_wdata = '0;
        inst_wmask = '0;
        data_ce    = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_wmask = '0;
        wait (reset == 1'b1);
        @(negedge aclk);
        data_port_sweep();
        inst_partial_masks();
        read_contention();
        write_then_read();
        write_contention();
        out_of_range();
        $display("Simulation passed");
        $finish;
    end

endmodule
